/* source/soc_pkg.sv */
`default_nettype none

package soc_pkg;

	// Wishbone widths
	localparam int WB_ADR_W = 32;
	localparam int WB_DAT_W = 32;
	localparam int WB_SEL_W = WB_DAT_W / 8;

	typedef logic [WB_ADR_W-1:0] wb_adr_t;
	typedef logic [WB_DAT_W-1:0] wb_dat_t;
	typedef logic [WB_SEL_W-1:0] wb_sel_t;

	//////////////////////////////
	// Address map
	//////////////////////////////

	// 256 words of main RAM at the bottom of the map
	localparam int RAM_ADR_BITS = 8;
	localparam wb_adr_t RAM_BASE = 32'h0000_0000;
	localparam wb_adr_t RAM_MASK = 32'h0000_03ff;

	typedef logic [RAM_ADR_BITS-1:0] ram_idx_t;

	// Two word registers of the transmitter
	localparam wb_adr_t UART_BASE = 32'h9000_0000;
	localparam wb_adr_t UART_MASK = 32'h0000_0007;
	localparam logic [2:0] UART_DATA_OFS = 3'h0;
	localparam logic [2:0] UART_STAT_OFS = 3'h4;

	//////////////////////////////
	// Serial timing
	//////////////////////////////
	localparam int UART_DIVISOR = 4;
	localparam int UART_DIV_BITS = $clog2(UART_DIVISOR);

	typedef logic [UART_DIV_BITS-1:0] uart_div_t;
	typedef logic [7:0] uart_byte_t;
	typedef logic [2:0] uart_bit_t;

	typedef enum logic [1:0] {IDLE, START, DATA, STOP} uart_state_t;

endpackage

`default_nettype wire

/* source/wb_bus_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface wb_bus_if;
	import soc_pkg::*;

	// Request, master to slave
	wb_adr_t adr;
	wb_dat_t dat_m2s;
	wb_sel_t sel;
	logic    we;
	logic    cyc;
	logic    stb;

	// Reply, slave to master
	wb_dat_t dat_s2m;
	logic    ack;
	logic    err;

	modport master (
		output adr, dat_m2s, sel, we, cyc, stb,
		input  dat_s2m, ack, err
	);

	modport slave (
		input  adr, dat_m2s, sel, we, cyc, stb,
		output dat_s2m, ack, err
	);

endinterface

`default_nettype wire

/* source/wb_intercon.sv */
`timescale 1ns/10ps
`default_nettype none

module wb_intercon (
	input  logic             wb_clk_i,
	input  logic             reset_i,
	input  soc_pkg::wb_adr_t wb_adr_i,
	input  soc_pkg::wb_dat_t wb_dat_i,
	input  soc_pkg::wb_sel_t wb_sel_i,
	input  logic             wb_we_i,
	input  logic             wb_cyc_i,
	input  logic             wb_stb_i,
	output soc_pkg::wb_dat_t wb_dat_o,
	output logic             wb_ack_o,
	output logic             wb_err_o,
	wb_bus_if.master         ram_bus,
	wb_bus_if.master         uart_bus
);
	import soc_pkg::*;

	logic ram_hit;
	logic uart_hit;
	logic slv_err;
	logic err_q;

	// Window decode
	assign ram_hit  = ((wb_adr_i & ~RAM_MASK) == RAM_BASE);
	assign uart_hit = ((wb_adr_i & ~UART_MASK) == UART_BASE);

	// Request goes to both, only the hit slave sees cyc and stb
	assign ram_bus.adr      = wb_adr_i;
	assign ram_bus.dat_m2s  = wb_dat_i;
	assign ram_bus.sel      = wb_sel_i;
	assign ram_bus.we       = wb_we_i;
	assign ram_bus.cyc      = wb_cyc_i & ram_hit;
	assign ram_bus.stb      = wb_stb_i & ram_hit;

	assign uart_bus.adr     = wb_adr_i;
	assign uart_bus.dat_m2s = wb_dat_i;
	assign uart_bus.sel     = wb_sel_i;
	assign uart_bus.we      = wb_we_i;
	assign uart_bus.cyc     = wb_cyc_i & uart_hit;
	assign uart_bus.stb     = wb_stb_i & uart_hit;

	// Reply mux
	always_comb begin
		wb_dat_o = '0;
		wb_ack_o = 1'b0;
		slv_err  = 1'b0;
		if (ram_hit) begin
			wb_dat_o = ram_bus.dat_s2m;
			wb_ack_o = ram_bus.ack;
			slv_err  = ram_bus.err;
		end else if (uart_hit) begin
			wb_dat_o = uart_bus.dat_s2m;
			wb_ack_o = uart_bus.ack;
			slv_err  = uart_bus.err;
		end
	end

	// Error slave for holes in the map, one pulse per request
	always_ff @(posedge wb_clk_i) begin
		if (reset_i) begin
			err_q <= 1'b0;
		end else begin
			err_q <= wb_cyc_i & wb_stb_i & ~ram_hit & ~uart_hit & ~err_q;
		end
	end

	assign wb_err_o = slv_err | err_q;

	a_ack_err_excl: assert property (@(posedge wb_clk_i) disable iff (reset_i)
		!(wb_ack_o && wb_err_o));

	a_one_slave: assert property (@(posedge wb_clk_i) disable iff (reset_i)
		!(ram_bus.stb && uart_bus.stb));

endmodule

`default_nettype wire

/* source/wb_ram.sv */
`timescale 1ns/10ps
`default_nettype none

module wb_ram (
	input  logic    wb_clk_i,
	input  logic    reset_i,
	wb_bus_if.slave bus
);
	import soc_pkg::*;

	wb_dat_t  mem [0:(1 << RAM_ADR_BITS)-1];
	ram_idx_t idx;
	wb_dat_t  rd_q;
	logic     ack_q;
	logic     req;

	// Word index from the byte address
	assign idx = bus.adr[RAM_ADR_BITS+1:2];

	// Blocked right after an ack so each request is served once
	assign req = bus.cyc & bus.stb & ~ack_q;

	always_ff @(posedge wb_clk_i) begin
		if (reset_i) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= req;
		end
	end

	// Storage with per-lane write enables
	always_ff @(posedge wb_clk_i) begin
		if (req && bus.we) begin
			for (int i = 0; i < WB_SEL_W; i++) begin
				if (bus.sel[i]) begin
					mem[idx][8*i +: 8] <= bus.dat_m2s[8*i +: 8];
				end
			end
		end
	end

	// Read data lands in the ack cycle
	always_ff @(posedge wb_clk_i) begin
		if (req) begin
			rd_q <= mem[idx];
		end
	end

	assign bus.dat_s2m = rd_q;
	assign bus.ack     = ack_q;
	assign bus.err     = 1'b0;

	a_ack_after_req: assert property (@(posedge wb_clk_i) disable iff (reset_i)
		ack_q |-> $past(bus.cyc && bus.stb));

	a_ack_single: assert property (@(posedge wb_clk_i) disable iff (reset_i)
		ack_q |=> !ack_q);

endmodule

`default_nettype wire

/* source/wb_uart_tx.sv */
`timescale 1ns/10ps
`default_nettype none

module wb_uart_tx (
	input  logic    wb_clk_i,
	input  logic    reset_i,
	wb_bus_if.slave bus,
	output logic    uart_tx_o
);
	import soc_pkg::*;

	uart_state_t state_q;
	uart_div_t   div_q;
	uart_bit_t   bit_q;
	uart_byte_t  shift_q;
	wb_dat_t     rd_q;
	logic        tx_q;
	logic        ack_q;
	logic        req;
	logic        data_wr;
	logic        stat_rd;
	logic        busy;
	logic        accept;
	logic        bit_end;

	//////////////////////////////
	// Register interface
	//////////////////////////////
	assign busy    = (state_q != IDLE);
	assign req     = bus.cyc & bus.stb & ~ack_q;
	assign data_wr = req & bus.we & (bus.adr[2:0] == UART_DATA_OFS);
	assign stat_rd = req & ~bus.we & (bus.adr[2:0] == UART_STAT_OFS);
	assign accept  = data_wr & ~busy;

	// A data write waits here until the frame in flight is done
	always_ff @(posedge wb_clk_i) begin
		if (reset_i) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= req & (~data_wr | ~busy);
		end
	end

	always_ff @(posedge wb_clk_i) begin
		if (req) begin
			rd_q <= stat_rd ? wb_dat_t'(busy) : '0;
		end
	end

	assign bus.dat_s2m = rd_q;
	assign bus.ack     = ack_q;
	assign bus.err     = 1'b0;

	//////////////////////////////
	// Transmitter
	//////////////////////////////
	assign bit_end = (div_q == uart_div_t'(UART_DIVISOR - 1));

	always_ff @(posedge wb_clk_i) begin
		if (reset_i) begin
			state_q <= IDLE;
			div_q   <= '0;
			bit_q   <= '0;
			tx_q    <= 1'b1;
		end else begin
			div_q <= bit_end ? '0 : div_q + 1'b1;
			case (state_q)
				IDLE: begin
					div_q <= '0;
					if (accept) begin
						state_q <= START;
						tx_q    <= 1'b0;
					end
				end
				START: begin
					if (bit_end) begin
						state_q <= DATA;
						bit_q   <= '0;
						tx_q    <= shift_q[0];
					end
				end
				DATA: begin
					if (bit_end) begin
						bit_q <= bit_q + 1'b1;
						// Last data bit done, go to stop
						if (bit_q == uart_bit_t'(7)) begin
							state_q <= STOP;
							tx_q    <= 1'b1;
						end else begin
							tx_q <= shift_q[1];
						end
					end
				end
				STOP: begin
					if (bit_end) begin
						state_q <= IDLE;
					end
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	// LSB first
	always_ff @(posedge wb_clk_i) begin
		if (accept) begin
			shift_q <= bus.dat_m2s[7:0];
		end else if (state_q == DATA && bit_end) begin
			shift_q <= shift_q >> 1;
		end
	end

	assign uart_tx_o = tx_q;

	a_idle_high: assert property (@(posedge wb_clk_i) disable iff (reset_i)
		(state_q == IDLE) |-> tx_q);

	a_start_low: assert property (@(posedge wb_clk_i) disable iff (reset_i)
		(state_q == START) |-> !tx_q);

	a_no_wr_ack_busy: assert property (@(posedge wb_clk_i) disable iff (reset_i)
		(ack_q && bus.we && bus.adr[2:0] == UART_DATA_OFS) |-> $past(state_q) == IDLE);

endmodule

`default_nettype wire

/* source/soc_top.sv */
`timescale 1ns/10ps
`default_nettype none

module soc_top (
	input  logic             wb_clk_i,
	input  logic             reset_i,
	input  soc_pkg::wb_adr_t wb_adr_i,
	input  soc_pkg::wb_dat_t wb_dat_i,
	input  soc_pkg::wb_sel_t wb_sel_i,
	input  logic             wb_we_i,
	input  logic             wb_cyc_i,
	input  logic             wb_stb_i,
	output soc_pkg::wb_dat_t wb_dat_o,
	output logic             wb_ack_o,
	output logic             wb_err_o,
	output logic             uart_tx_o
);

	//////////////////////////////
	// Wishbone interconnect
	//////////////////////////////
	wb_bus_if ram_bus ();
	wb_bus_if uart_bus ();

	// Top-level port is the single bus master
	wb_intercon u_wb_intercon (
		.wb_clk_i (wb_clk_i),
		.reset_i  (reset_i),
		.wb_adr_i (wb_adr_i),
		.wb_dat_i (wb_dat_i),
		.wb_sel_i (wb_sel_i),
		.wb_we_i  (wb_we_i),
		.wb_cyc_i (wb_cyc_i),
		.wb_stb_i (wb_stb_i),
		.wb_dat_o (wb_dat_o),
		.wb_ack_o (wb_ack_o),
		.wb_err_o (wb_err_o),
		.ram_bus  (ram_bus.master),
		.uart_bus (uart_bus.master)
	);

	//////////////////////////////
	// Main RAM
	//////////////////////////////
	wb_ram u_wb_ram (
		.wb_clk_i (wb_clk_i),
		.reset_i  (reset_i),
		.bus      (ram_bus.slave)
	);

	//////////////////////////////
	// UART, transmit only
	//////////////////////////////
	wb_uart_tx u_wb_uart_tx (
		.wb_clk_i  (wb_clk_i),
		.reset_i   (reset_i),
		.bus       (uart_bus.slave),
		.uart_tx_o (uart_tx_o)
	);

endmodule

`default_nettype wire

/* testbench/tb_soc_top.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_soc_top;
	import soc_pkg::*;

	// The whole sequence needs roughly 450 cycles
	localparam int      TIMEOUT_CYCLES = 3000;
	localparam int      RAM_WORDS      = 1 << RAM_ADR_BITS;
	localparam wb_adr_t UART_DATA_ADR  = UART_BASE | wb_adr_t'(UART_DATA_OFS);
	localparam wb_adr_t UART_STAT_ADR  = UART_BASE | wb_adr_t'(UART_STAT_OFS);
	localparam wb_adr_t UNMAPPED_ADR   = 32'h4000_0000;

	logic       wb_clk;
	logic       reset;
	wb_adr_t    wb_adr;
	wb_dat_t    wb_dat_w;
	wb_sel_t    wb_sel;
	logic       wb_we;
	logic       wb_cyc;
	logic       wb_stb;
	wb_dat_t    wb_dat_r;
	logic       wb_ack;
	logic       wb_err;
	logic       uart_tx;
	logic       ram_win;
	logic       uart_win;
	int         cycle_cnt = 0;

	wb_dat_t    ref_mem [0:RAM_WORDS-1];
	uart_byte_t sent_q [$];
	uart_byte_t rx_q [$];

	soc_top u_soc_top (
		.wb_clk_i  (wb_clk),
		.reset_i   (reset),
		.wb_adr_i  (wb_adr),
		.wb_dat_i  (wb_dat_w),
		.wb_sel_i  (wb_sel),
		.wb_we_i   (wb_we),
		.wb_cyc_i  (wb_cyc),
		.wb_stb_i  (wb_stb),
		.wb_dat_o  (wb_dat_r),
		.wb_ack_o  (wb_ack),
		.wb_err_o  (wb_err),
		.uart_tx_o (uart_tx)
	);

	initial wb_clk = 1'b0;
	always #10 wb_clk = ~wb_clk;

	// Address windows seen from the master
	assign ram_win  = (wb_adr[31:10] == '0);
	assign uart_win = (wb_adr[31:3] == UART_BASE[31:3]);

	task automatic abort_run();
		$display("** FAIL **");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input wb_dat_t got, input wb_dat_t exp);
		assert (got === exp) else begin
			$display("MISMATCH %s got 0x%08h expected 0x%08h", name, got, exp);
			abort_run();
		end
	endtask

	function automatic wb_adr_t word_address(input int idx);
		return wb_adr_t'(idx) << 2;
	endfunction

	function automatic wb_dat_t merge_lanes(input wb_dat_t old_dat, input wb_dat_t new_dat,
			input wb_sel_t sel);
		wb_dat_t res;
		res = old_dat;
		for (int i = 0; i < WB_SEL_W; i++) begin
			if (sel[i]) begin
				res[8*i +: 8] = new_dat[8*i +: 8];
			end
		end
		return res;
	endfunction

	// One classic cycle, ends on ack or err
	task automatic transfer(input logic we, input wb_adr_t adr, input wb_dat_t dat,
			input wb_sel_t sel, output wb_dat_t rd, output logic err, output int cycles);
		cycles = 0;
		@(posedge wb_clk);
		wb_adr   <= adr;
		wb_dat_w <= dat;
		wb_sel   <= sel;
		wb_we    <= we;
		wb_cyc   <= 1'b1;
		wb_stb   <= 1'b1;
		do begin
			@(posedge wb_clk);
			cycles++;
		end while (!(wb_ack || wb_err));
		rd  = wb_dat_r;
		err = wb_err;
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
	endtask

	//////////////////////////////
	// Serial decoder
	//////////////////////////////
	always begin : serial_decoder
		uart_byte_t rx_byte;
		@(negedge uart_tx);
		// Middle of the start bit
		repeat (UART_DIVISOR / 2) @(posedge wb_clk);
		check_value("uart_tx_o start bit", wb_dat_t'(uart_tx), 32'h0);
		for (int i = 0; i < 8; i++) begin
			repeat (UART_DIVISOR) @(posedge wb_clk);
			rx_byte[i] = uart_tx;
		end
		repeat (UART_DIVISOR) @(posedge wb_clk);
		check_value("uart_tx_o stop bit", wb_dat_t'(uart_tx), 32'h1);
		rx_q.push_back(rx_byte);
	end

	always @(posedge wb_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, the test sequence did not finish", cycle_cnt);
			abort_run();
		end
	end

	a_ram_ack: assert property (@(posedge wb_clk) disable iff (reset)
		($rose(wb_stb) && ram_win) |=> (wb_ack && !wb_err))
		else begin
			$display("RAM ack did not come one cycle after the strobe");
			abort_run();
		end

	a_hole_err: assert property (@(posedge wb_clk) disable iff (reset)
		($rose(wb_stb) && !ram_win && !uart_win) |=> (wb_err && !wb_ack))
		else begin
			$display("Unmapped access did not get a single err one cycle later");
			abort_run();
		end

	a_stat_ack: assert property (@(posedge wb_clk) disable iff (reset)
		($rose(wb_stb) && uart_win && !wb_we) |=> wb_ack)
		else begin
			$display("UART status read was not acknowledged one cycle later");
			abort_run();
		end

	//////////////////////////////
	// Test sequence
	//////////////////////////////
	initial begin
		int         idx_list [32];
		wb_dat_t    dat;
		wb_dat_t    rd;
		wb_sel_t    sel;
		logic       err;
		int         cycles;
		uart_byte_t tx_byte;

		void'($urandom(65));
		reset    = 1'b1;
		wb_adr   = '0;
		wb_dat_w = '0;
		wb_sel   = '0;
		wb_we    = 1'b0;
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		repeat (8) @(posedge wb_clk);
		reset <= 1'b0;
		@(posedge wb_clk);
		check_value("wb_ack_o", wb_dat_t'(wb_ack), 32'h0);
		check_value("wb_err_o", wb_dat_t'(wb_err), 32'h0);
		check_value("uart_tx_o", wb_dat_t'(uart_tx), 32'h1);
		transfer(1'b0, UART_STAT_ADR, '0, 4'hf, rd, err, cycles);
		check_value("uart status", rd, 32'h0);

		// Full words, then readback
		for (int n = 0; n < 32; n++) begin
			idx_list[n] = $urandom_range(RAM_WORDS - 1);
			dat = $urandom;
			ref_mem[idx_list[n]] = dat;
			transfer(1'b1, word_address(idx_list[n]), dat, 4'hf, rd, err, cycles);
		end
		for (int n = 0; n < 32; n++) begin
			transfer(1'b0, word_address(idx_list[n]), '0, 4'hf, rd, err, cycles);
			check_value("wb_dat_o", rd, ref_mem[idx_list[n]]);
		end

		// Byte lanes over words already known
		for (int n = 0; n < 16; n++) begin
			sel = wb_sel_t'($urandom_range(15));
			dat = $urandom;
			ref_mem[idx_list[n]] = merge_lanes(ref_mem[idx_list[n]], dat, sel);
			transfer(1'b1, word_address(idx_list[n]), dat, sel, rd, err, cycles);
		end
		for (int n = 0; n < 16; n++) begin
			transfer(1'b0, word_address(idx_list[n]), '0, 4'hf, rd, err, cycles);
			check_value("wb_dat_o lanes", rd, ref_mem[idx_list[n]]);
		end

		// Hole in the map, then the RAM again
		transfer(1'b0, UNMAPPED_ADR, '0, 4'hf, rd, err, cycles);
		check_value("wb_err_o", wb_dat_t'(err), 32'h1);
		transfer(1'b1, UNMAPPED_ADR | 32'h10, 32'hdead_beef, 4'hf, rd, err, cycles);
		check_value("wb_err_o", wb_dat_t'(err), 32'h1);
		transfer(1'b0, word_address(idx_list[0]), '0, 4'hf, rd, err, cycles);
		check_value("wb_err_o", wb_dat_t'(err), 32'h0);
		check_value("wb_dat_o", rd, ref_mem[idx_list[0]]);

		// Three frames back to back
		for (int n = 0; n < 3; n++) begin
			tx_byte = uart_byte_t'($urandom);
			sent_q.push_back(tx_byte);
			transfer(1'b1, UART_DATA_ADR, wb_dat_t'(tx_byte), 4'h1, rd, err, cycles);
			if (n == 0) begin
				// Request edge plus ack edge
				check_value("first uart write latency", wb_dat_t'(cycles), 32'h2);
				transfer(1'b0, UART_STAT_ADR, '0, 4'hf, rd, err, cycles);
				check_value("uart status", rd, 32'h1);
			end else begin
				// Every earlier frame is already out on the line
				assert (rx_q.size() == n) else begin
					$display("UART data write %0d was acknowledged while a frame was in flight", n);
					abort_run();
				end
			end
		end
		while (rx_q.size() < 3) begin
			@(posedge wb_clk);
		end
		// Let the last stop bit run out
		repeat (UART_DIVISOR) @(posedge wb_clk);
		transfer(1'b0, UART_STAT_ADR, '0, 4'hf, rd, err, cycles);
		check_value("uart status", rd, 32'h0);
		for (int n = 0; n < 3; n++) begin
			check_value("received byte", wb_dat_t'(rx_q[n]), wb_dat_t'(sent_q[n]));
		end

		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
source/soc_pkg.sv
source/wb_bus_if.sv
source/wb_intercon.sv
source/wb_ram.sv
source/wb_uart_tx.sv
source/soc_top.sv
testbench/tb_soc_top.sv

/* Bender.yml */
package:
  name: soc_top

sources:
  - source/soc_pkg.sv
  - source/wb_bus_if.sv
  - source/wb_intercon.sv
  - source/wb_ram.sv
  - source/wb_uart_tx.sv
  - source/soc_top.sv
  - target: test
    files:
      - testbench/tb_soc_top.sv
